// ==== run_sim.sh ====
#!/bin/sh
# compile and run the read upsizer testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/10ps \
    --top-module tb_axi_rd_upsizer -f tb.f -o sim_tb > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/sim_tb > sim.log 2>&1
cat sim.log
grep -q -e ">>> FAIL" -e "%Error" sim.log && { echo "simulation failed"; exit 1; }
grep -q ">>> PASS" sim.log || { echo "simulation ended without a result"; exit 1; }
echo "simulation passed"

// ==== src/ar_request_unit.sv ====
// AR request control
`timescale 1ns/10ps
`include "rd_upsizer_consts.svh"

module ar_request_unit (
    input  logic                    clk,
    input  logic                    rst,
    input  rd_upsizer_pkg::ar_req_t s_ar_req,
    input  logic                    s_arvalid,
    output logic                    s_arready,
    output rd_upsizer_pkg::ar_req_t m_ar_req,
    output logic                    m_arvalid,
    input  logic                    m_arready,
    burst_ctl_if.ctl                ctl
);

    logic                        busy;
    logic                        s_arready_reg;
    logic                        m_arvalid_reg;
    logic                        start_reg;
    rd_upsizer_pkg::ar_req_t     req_reg;
    rd_upsizer_pkg::burst_mode_t mode_reg;
    logic [7:0]                  m_len_reg;
    logic [2:0]                  m_size_reg;
    logic                        ar_fire;
    logic                        split_req;
    logic [7:0]                  split_len;

    assign ar_fire = s_arready_reg && s_arvalid;

    // full-width beats on a modifiable burst get repacked
    assign split_req = s_ar_req.cache[`RDU_CACHE_MOD_BIT] &&
                       (s_ar_req.size == 3'(`RDU_S_SIZE));

    // starting lane counts toward the wide beats touched
    assign split_len = 8'((9'(s_ar_req.len) +
                           9'(s_ar_req.addr[`RDU_M_SIZE-1:`RDU_S_SIZE])) >> `RDU_SEG_CNT_W);

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
            s_arready_reg <= 1'b0;
            m_arvalid_reg <= 1'b0;
            start_reg <= 1'b0;
        end else begin
            start_reg <= ar_fire;
            m_arvalid_reg <= ar_fire || (m_arvalid_reg && !m_arready);
            if (!busy) begin
                busy <= ar_fire;
                s_arready_reg <= !ar_fire && !m_arvalid_reg;
            end else begin
                // stay closed until the unpacker has drained the burst
                busy <= !ctl.done;
                s_arready_reg <= ctl.done && !m_arvalid_reg;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ar_fire) begin
            req_reg <= s_ar_req;
            if (split_req) begin
                mode_reg <= rd_upsizer_pkg::MODE_SPLIT;
                m_len_reg <= split_len;
                m_size_reg <= 3'(`RDU_M_SIZE);
            end else begin
                mode_reg <= rd_upsizer_pkg::MODE_PASS;
                m_len_reg <= s_ar_req.len;
                m_size_reg <= s_ar_req.size;
            end
        end
    end

    assign s_arready = s_arready_reg;
    assign m_arvalid = m_arvalid_reg;

    // master side always sees id zero
    always_comb begin
        m_ar_req = req_reg;
        m_ar_req.id = '0;
        m_ar_req.len = m_len_reg;
        m_ar_req.size = m_size_reg;
    end

    assign ctl.start = start_reg;
    assign ctl.req = req_reg;
    assign ctl.mode = mode_reg;

endmodule

// ==== src/axi_rd_upsizer.sv ====
// AXI read upsizer top
`timescale 1ns/10ps
`include "rd_upsizer_consts.svh"

module axi_rd_upsizer (
    input  logic                     clk,
    input  logic                     rst,

    // slave side, 32-bit
    input  logic [`RDU_ID_W-1:0]     s_arid,
    input  logic [`RDU_ADDR_W-1:0]   s_araddr,
    input  logic [7:0]               s_arlen,
    input  logic [2:0]               s_arsize,
    input  logic [1:0]               s_arburst,
    input  logic [3:0]               s_arcache,
    input  logic                     s_arvalid,
    output logic                     s_arready,
    output logic [`RDU_ID_W-1:0]     s_rid,
    output logic [`RDU_S_DATA_W-1:0] s_rdata,
    output logic [1:0]               s_rresp,
    output logic                     s_rlast,
    output logic                     s_rvalid,
    input  logic                     s_rready,

    // master side, 128-bit
    output logic [`RDU_ID_W-1:0]     m_arid,
    output logic [`RDU_ADDR_W-1:0]   m_araddr,
    output logic [7:0]               m_arlen,
    output logic [2:0]               m_arsize,
    output logic [1:0]               m_arburst,
    output logic [3:0]               m_arcache,
    output logic                     m_arvalid,
    input  logic                     m_arready,
    input  logic [`RDU_M_DATA_W-1:0] m_rdata,
    input  logic [1:0]               m_rresp,
    input  logic                     m_rlast,
    input  logic                     m_rvalid,
    output logic                     m_rready
);

    rd_upsizer_pkg::ar_req_t s_ar_req;
    rd_upsizer_pkg::ar_req_t m_ar_req;
    rd_upsizer_pkg::r_beat_t beat;
    logic                    beat_valid;
    logic                    ready_early;

    burst_ctl_if ctl_if ();

    assign s_ar_req = '{
        id:    s_arid,
        addr:  s_araddr,
        len:   s_arlen,
        size:  s_arsize,
        burst: s_arburst,
        cache: s_arcache
    };

    assign m_arid = m_ar_req.id;
    assign m_araddr = m_ar_req.addr;
    assign m_arlen = m_ar_req.len;
    assign m_arsize = m_ar_req.size;
    assign m_arburst = m_ar_req.burst;
    assign m_arcache = m_ar_req.cache;

    ar_request_unit ar_unit (
        .clk       (clk),
        .rst       (rst),
        .s_ar_req  (s_ar_req),
        .s_arvalid (s_arvalid),
        .s_arready (s_arready),
        .m_ar_req  (m_ar_req),
        .m_arvalid (m_arvalid),
        .m_arready (m_arready),
        .ctl       (ctl_if.ctl)
    );

    r_lane_unpacker unpacker (
        .clk         (clk),
        .rst         (rst),
        .dp          (ctl_if.dp),
        .m_rdata     (m_rdata),
        .m_rresp     (m_rresp),
        .m_rlast     (m_rlast),
        .m_rvalid    (m_rvalid),
        .m_rready    (m_rready),
        .beat        (beat),
        .beat_valid  (beat_valid),
        .ready_early (ready_early)
    );

    r_output_skid out_skid (
        .clk         (clk),
        .rst         (rst),
        .in_beat     (beat),
        .in_valid    (beat_valid),
        .ready_early (ready_early),
        .s_rid       (s_rid),
        .s_rdata     (s_rdata),
        .s_rresp     (s_rresp),
        .s_rlast     (s_rlast),
        .s_rvalid    (s_rvalid),
        .s_rready    (s_rready)
    );

endmodule

// ==== src/burst_ctl_if.sv ====
// Burst control handshake
`timescale 1ns/10ps

interface burst_ctl_if;

    // one-cycle pulse when a request has been accepted
    logic                        start;

    // original request, id included, and the chosen conversion
    rd_upsizer_pkg::ar_req_t     req;
    rd_upsizer_pkg::burst_mode_t mode;

    // one-cycle pulse on the final slave beat
    logic                        done;

    modport ctl (
        output start,
        output req,
        output mode,
        input  done
    );

    modport dp (
        input  start,
        input  req,
        input  mode,
        output done
    );

endinterface

// ==== src/r_lane_unpacker.sv ====
// R lane unpacker
`timescale 1ns/10ps
`include "rd_upsizer_consts.svh"

module r_lane_unpacker (
    input  logic                     clk,
    input  logic                     rst,
    burst_ctl_if.dp                  dp,
    input  logic [`RDU_M_DATA_W-1:0] m_rdata,
    input  logic [1:0]               m_rresp,
    input  logic                     m_rlast,
    input  logic                     m_rvalid,
    output logic                     m_rready,
    output rd_upsizer_pkg::r_beat_t  beat,
    output logic                     beat_valid,
    input  logic                     ready_early
);

    localparam int S_DATA_W = `RDU_S_DATA_W;
    localparam int ADDR_W = `RDU_ADDR_W;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_DATA,
        ST_READ,
        ST_SPLIT
    } state_t;

    state_t                     state;
    state_t                     state_next;
    logic [`RDU_ID_W-1:0]       id_reg;
    logic [ADDR_W-1:0]          addr_reg;
    logic [ADDR_W-1:0]          addr_next;
    logic [ADDR_W-1:0]          addr_inc;
    logic [7:0]                 count_reg;
    logic [7:0]                 count_next;
    logic [2:0]                 size_reg;
    logic [`RDU_M_DATA_W-1:0]   data_reg;
    logic [1:0]                 resp_reg;
    logic                       rready_reg;
    logic                       rready_next;
    logic                       ready_reg;
    logic                       m_fire;
    logic                       load;
    logic                       capture;
    logic                       crossed;
    logic [`RDU_SEG_CNT_W-1:0]  lane;

    assign m_fire = rready_reg && m_rvalid;
    assign load = (state == ST_IDLE) && dp.start;
    assign lane = addr_reg[`RDU_M_SIZE-1:`RDU_S_SIZE];
    assign addr_inc = addr_reg + (ADDR_W'(1) << size_reg);

    // next slave beat lives in a different wide word
    assign crossed = addr_inc[`RDU_M_SIZE] != addr_reg[`RDU_M_SIZE];

    assign m_rready = rready_reg;

    always_comb begin
        state_next = state;
        addr_next = addr_reg;
        count_next = count_reg;
        rready_next = 1'b0;
        capture = 1'b0;
        beat_valid = 1'b0;
        dp.done = 1'b0;

        beat.id = id_reg;
        beat.data = m_rdata[lane * S_DATA_W +: S_DATA_W];
        beat.resp = m_rresp;
        beat.last = m_rlast;

        case (state)
            ST_IDLE: begin
                if (dp.start) begin
                    addr_next = dp.req.addr;
                    count_next = dp.req.len;
                    rready_next = ready_early;
                    if (dp.mode == rd_upsizer_pkg::MODE_SPLIT) begin
                        state_next = ST_READ;
                    end else begin
                        state_next = ST_DATA;
                    end
                end
            end
            ST_DATA: begin
                // pass-through, master last ends the burst
                rready_next = ready_early;
                if (m_fire) begin
                    beat_valid = 1'b1;
                    addr_next = addr_inc;
                    if (m_rlast) begin
                        rready_next = 1'b0;
                        dp.done = 1'b1;
                        state_next = ST_IDLE;
                    end
                end
            end
            ST_READ: begin
                rready_next = ready_early;
                if (m_fire) begin
                    beat_valid = 1'b1;
                    capture = 1'b1;
                    beat.last = 1'b0;
                    count_next = count_reg - 8'd1;
                    addr_next = addr_inc;
                    if (count_reg == 8'd0) begin
                        rready_next = 1'b0;
                        beat.last = 1'b1;
                        dp.done = 1'b1;
                        state_next = ST_IDLE;
                    end else if (!crossed) begin
                        // more lanes left in this wide beat
                        rready_next = 1'b0;
                        state_next = ST_SPLIT;
                    end
                end
            end
            ST_SPLIT: begin
                beat.data = data_reg[lane * S_DATA_W +: S_DATA_W];
                beat.resp = resp_reg;
                beat.last = 1'b0;
                if (ready_reg) begin
                    beat_valid = 1'b1;
                    count_next = count_reg - 8'd1;
                    addr_next = addr_inc;
                    if (count_reg == 8'd0) begin
                        beat.last = 1'b1;
                        dp.done = 1'b1;
                        state_next = ST_IDLE;
                    end else if (crossed) begin
                        rready_next = ready_early;
                        state_next = ST_READ;
                    end
                end
            end
            default: begin
                state_next = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_IDLE;
            rready_reg <= 1'b0;
            ready_reg <= 1'b0;
        end else begin
            state <= state_next;
            rready_reg <= rready_next;
            ready_reg <= ready_early;
        end
    end

    always_ff @(posedge clk) begin
        addr_reg <= addr_next;
        count_reg <= count_next;
        if (load) begin
            id_reg <= dp.req.id;
            size_reg <= dp.req.size;
        end
        // wide beat kept for the split replay
        if (capture) begin
            data_reg <= m_rdata;
            resp_reg <= m_rresp;
        end
    end

endmodule

// ==== src/r_output_skid.sv ====
// R output skid stage
`timescale 1ns/10ps
`include "rd_upsizer_consts.svh"

module r_output_skid (
    input  logic                     clk,
    input  logic                     rst,
    input  rd_upsizer_pkg::r_beat_t  in_beat,
    input  logic                     in_valid,
    output logic                     ready_early,
    output logic [`RDU_ID_W-1:0]     s_rid,
    output logic [`RDU_S_DATA_W-1:0] s_rdata,
    output logic [1:0]               s_rresp,
    output logic                     s_rlast,
    output logic                     s_rvalid,
    input  logic                     s_rready
);

    rd_upsizer_pkg::r_beat_t out_reg;
    rd_upsizer_pkg::r_beat_t temp_reg;
    logic                    out_valid;
    logic                    out_valid_next;
    logic                    temp_valid;
    logic                    temp_valid_next;
    logic                    in_ready_reg;
    logic                    in_to_out;
    logic                    in_to_temp;
    logic                    temp_to_out;

    // room next cycle unless the temp register would have to take a beat
    assign ready_early = s_rready || (!temp_valid && (!out_valid || !in_valid));

    always_comb begin
        out_valid_next = out_valid;
        temp_valid_next = temp_valid;
        in_to_out = 1'b0;
        in_to_temp = 1'b0;
        temp_to_out = 1'b0;

        if (in_ready_reg) begin
            if (s_rready || !out_valid) begin
                out_valid_next = in_valid;
                in_to_out = 1'b1;
            end else begin
                // output stalled
                temp_valid_next = in_valid;
                in_to_temp = 1'b1;
            end
        end else if (s_rready) begin
            out_valid_next = temp_valid;
            temp_valid_next = 1'b0;
            temp_to_out = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
            temp_valid <= 1'b0;
            in_ready_reg <= 1'b0;
        end else begin
            out_valid <= out_valid_next;
            temp_valid <= temp_valid_next;
            in_ready_reg <= ready_early;
        end
    end

    always_ff @(posedge clk) begin
        if (in_to_out) begin
            out_reg <= in_beat;
        end else if (temp_to_out) begin
            out_reg <= temp_reg;
        end
        if (in_to_temp) begin
            temp_reg <= in_beat;
        end
    end

    assign s_rid = out_reg.id;
    assign s_rdata = out_reg.data;
    assign s_rresp = out_reg.resp;
    assign s_rlast = out_reg.last;
    assign s_rvalid = out_valid;

endmodule

// ==== src/rd_upsizer_consts.svh ====
// Read upsizer constants

`ifndef RD_UPSIZER_CONSTS_SVH
`define RD_UPSIZER_CONSTS_SVH

// data widths of the narrow slave side and the wide master side
`define RDU_S_DATA_W 32
`define RDU_M_DATA_W 128

`define RDU_ADDR_W 32
`define RDU_ID_W 4

// AXI size codes for a full beat on each side
`define RDU_S_SIZE 2
`define RDU_M_SIZE 4

// lane index into a wide beat, log2 of M/S width ratio
`define RDU_SEG_CNT_W 2

// arcache bit that allows the burst to be modified
`define RDU_CACHE_MOD_BIT 1

`endif

// ==== src/rd_upsizer_pkg.sv ====
// Read upsizer types

`include "rd_upsizer_consts.svh"

package rd_upsizer_pkg;

    // read address request, one AR transfer
    typedef struct packed {
        logic [`RDU_ID_W-1:0]   id;
        logic [`RDU_ADDR_W-1:0] addr;
        logic [7:0]             len;
        logic [2:0]             size;
        logic [1:0]             burst;
        logic [3:0]             cache;
    } ar_req_t;

    // one narrow read beat toward the slave port
    typedef struct packed {
        logic [`RDU_ID_W-1:0]     id;
        logic [`RDU_S_DATA_W-1:0] data;
        logic [1:0]               resp;
        logic                     last;
    } r_beat_t;

    // split repacks into full wide beats, pass sends the burst through as is
    typedef enum logic {
        MODE_SPLIT,
        MODE_PASS
    } burst_mode_t;

endpackage

// ==== tb.f ====
+incdir+src
src/rd_upsizer_pkg.sv
src/burst_ctl_if.sv
src/ar_request_unit.sv
src/r_lane_unpacker.sv
src/r_output_skid.sv
src/axi_rd_upsizer.sv
tb/axi_rd_upsizer_sva.sv
tb/tb_axi_rd_upsizer.sv

// ==== tb/axi_rd_upsizer_sva.sv ====
// Read upsizer port assertions
`timescale 1ns/10ps

module axi_rd_upsizer_sva (
    input logic clk,
    input logic rst,
    input logic s_arvalid,
    input logic s_arready,
    input logic s_rvalid,
    input logic s_rready,
    input logic m_arvalid,
    input logic m_arready,
    input logic m_rvalid,
    input logic m_rready
);

    // valid stays up until the transfer
    s_ar_hold: assert property (@(posedge clk) disable iff (rst)
        s_arvalid && !s_arready |=> s_arvalid)
        else $error("slave arvalid dropped before arready");

    m_ar_hold: assert property (@(posedge clk) disable iff (rst)
        m_arvalid && !m_arready |=> m_arvalid)
        else $error("master arvalid dropped before arready");

    s_r_hold: assert property (@(posedge clk) disable iff (rst)
        s_rvalid && !s_rready |=> s_rvalid)
        else $error("slave rvalid dropped before rready");

    m_r_hold: assert property (@(posedge clk) disable iff (rst)
        m_rvalid && !m_rready |=> m_rvalid)
        else $error("master rvalid dropped before rready");

    reset_quiet: assert property (@(posedge clk)
        $past(rst) |-> !s_arready && !m_arvalid && !m_rready && !s_rvalid)
        else $error("handshake output high during reset");

    // a new slave request waits for the master request to leave
    ar_exclusive: assert property (@(posedge clk) disable iff (rst)
        !(s_arready && m_arvalid))
        else $error("slave arready high while master arvalid pending");

endmodule

bind axi_rd_upsizer axi_rd_upsizer_sva sva_inst (
    .clk       (clk),
    .rst       (rst),
    .s_arvalid (s_arvalid),
    .s_arready (s_arready),
    .s_rvalid  (s_rvalid),
    .s_rready  (s_rready),
    .m_arvalid (m_arvalid),
    .m_arready (m_arready),
    .m_rvalid  (m_rvalid),
    .m_rready  (m_rready)
);

// ==== tb/rd_upsizer_golden.txt ====
// id addr len size burst cache | expected master len, master size | resp to return
// split conversion: cache bit 1 set and size 2
1 00000100 07 2 1 3 01 4 0
2 00000208 05 2 1 2 01 4 1
3 0000030c 00 2 1 f 00 4 2
4 00000404 0f 2 1 3 04 4 0
5 00000500 03 2 1 2 00 4 3
6 00000614 0a 2 1 3 02 4 0
7 00000700 1f 2 1 b 07 4 2
8 00000838 02 2 1 7 01 4 0
// pass-through: cache bit 1 clear or narrow size
9 00000900 03 2 1 0 03 2 0
a 00000a02 05 1 1 3 05 1 1
b 00000b01 07 0 1 2 07 0 0
c 00000c08 00 2 1 1 00 2 2
d 00000d10 0f 2 1 0 0f 2 0
e 00000e06 02 1 1 3 02 1 3

// ==== tb/tb_axi_rd_upsizer.sv ====
// AXI read upsizer testbench
`timescale 1ns/10ps
`include "rd_upsizer_consts.svh"

module tb_axi_rd_upsizer;

    localparam int NUM_BURSTS = 14;
    localparam int NUM_FIELDS = 9;
    localparam int CYCLE_LIMIT = 200 * NUM_BURSTS + 100;

    // columns of one golden line
    localparam int F_ID = 0;
    localparam int F_ADDR = 1;
    localparam int F_LEN = 2;
    localparam int F_SIZE = 3;
    localparam int F_BURST = 4;
    localparam int F_CACHE = 5;
    localparam int F_MLEN = 6;
    localparam int F_MSIZE = 7;
    localparam int F_RESP = 8;

    logic                     clk;
    logic                     rst;
    logic [`RDU_ID_W-1:0]     s_arid;
    logic [`RDU_ADDR_W-1:0]   s_araddr;
    logic [7:0]               s_arlen;
    logic [2:0]               s_arsize;
    logic [1:0]               s_arburst;
    logic [3:0]               s_arcache;
    logic                     s_arvalid;
    logic                     s_arready;
    logic [`RDU_ID_W-1:0]     s_rid;
    logic [`RDU_S_DATA_W-1:0] s_rdata;
    logic [1:0]               s_rresp;
    logic                     s_rlast;
    logic                     s_rvalid;
    logic                     s_rready;
    logic [`RDU_ID_W-1:0]     m_arid;
    logic [`RDU_ADDR_W-1:0]   m_araddr;
    logic [7:0]               m_arlen;
    logic [2:0]               m_arsize;
    logic [1:0]               m_arburst;
    logic [3:0]               m_arcache;
    logic                     m_arvalid;
    logic                     m_arready;
    logic [`RDU_M_DATA_W-1:0] m_rdata;
    logic [1:0]               m_rresp;
    logic                     m_rlast;
    logic                     m_rvalid;
    logic                     m_rready;

    logic [31:0] golden [0:NUM_BURSTS*NUM_FIELDS-1];
    integer      seed;
    int          cycles = 0;
    int          ar_errors;
    int          r_errors;
    int          req_sent;
    int          rsp_idx;
    int          beat_n;

    axi_rd_upsizer axi_rd_upsizer_inst (
        .clk       (clk),
        .rst       (rst),
        .s_arid    (s_arid),
        .s_araddr  (s_araddr),
        .s_arlen   (s_arlen),
        .s_arsize  (s_arsize),
        .s_arburst (s_arburst),
        .s_arcache (s_arcache),
        .s_arvalid (s_arvalid),
        .s_arready (s_arready),
        .s_rid     (s_rid),
        .s_rdata   (s_rdata),
        .s_rresp   (s_rresp),
        .s_rlast   (s_rlast),
        .s_rvalid  (s_rvalid),
        .s_rready  (s_rready),
        .m_arid    (m_arid),
        .m_araddr  (m_araddr),
        .m_arlen   (m_arlen),
        .m_arsize  (m_arsize),
        .m_arburst (m_arburst),
        .m_arcache (m_arcache),
        .m_arvalid (m_arvalid),
        .m_arready (m_arready),
        .m_rdata   (m_rdata),
        .m_rresp   (m_rresp),
        .m_rlast   (m_rlast),
        .m_rvalid  (m_rvalid),
        .m_rready  (m_rready)
    );

    always #2 clk = ~clk;

    function automatic logic [31:0] field(input int burst, input int col);
        return golden[burst * NUM_FIELDS + col];
    endfunction

    // AXI address of beat n of an INCR burst
    function automatic logic [31:0] beat_addr(input logic [31:0] start, input logic [2:0] size,
                                              input int n);
        logic [31:0] bytes;
        bytes = 32'd1 << size;
        if (n == 0) begin
            return start;
        end
        return (start & ~(bytes - 32'd1)) + bytes * 32'(n);
    endfunction

    // memory rule: every byte holds the low byte of its own address
    function automatic logic [127:0] wide_word(input logic [31:0] addr);
        logic [127:0] w;
        logic [7:0]   base;
        base = {addr[7:4], 4'h0};
        for (int k = 0; k < 16; k++) begin
            w[k*8 +: 8] = base + 8'(k);
        end
        return w;
    endfunction

    function automatic logic [31:0] lane_bytes(input logic [31:0] addr);
        logic [7:0] base;
        base = {addr[7:2], 2'b00};
        return {base + 8'd3, base + 8'd2, base + 8'd1, base};
    endfunction

    task automatic check_arready_after_reset;
        int waited;
        waited = 0;
        while (!s_arready && waited < 4) begin
            @(negedge clk);
            waited++;
        end
        if (!s_arready) begin
            $display("[FAIL] %0t: arready still low %0d cycles after reset", $time, waited);
            ar_errors++;
        end
        if (s_rvalid) begin
            $display("[FAIL] %0t: slave rvalid high before any request", $time);
            r_errors++;
        end
    endtask

    task automatic send_request(input int b);
        s_arid = 4'(field(b, F_ID));
        s_araddr = field(b, F_ADDR);
        s_arlen = 8'(field(b, F_LEN));
        s_arsize = 3'(field(b, F_SIZE));
        s_arburst = 2'(field(b, F_BURST));
        s_arcache = 4'(field(b, F_CACHE));
        s_arvalid = 1'b1;
        req_sent = b + 1;
        while (!s_arready) @(negedge clk);
        // transfer happens on the rising edge in between
        @(negedge clk);
        s_arvalid = 1'b0;
    endtask

    task automatic check_master_ar(input int idx);
        if (idx >= NUM_BURSTS) begin
            $display("[FAIL] %0t: unexpected master request at %h", $time, m_araddr);
            ar_errors++;
        end else begin
            if (m_arlen !== 8'(field(idx, F_MLEN)) || m_arsize !== 3'(field(idx, F_MSIZE))) begin
                $display("[FAIL] %0t: burst %0d master len %h size %0d, expected %h %0d",
                         $time, idx, m_arlen, m_arsize, field(idx, F_MLEN), field(idx, F_MSIZE));
                ar_errors++;
            end
            if (m_araddr !== field(idx, F_ADDR) || m_arid !== '0) begin
                $display("[FAIL] %0t: burst %0d master addr %h id %h", $time, idx,
                         m_araddr, m_arid);
                ar_errors++;
            end
            if (m_arburst !== 2'(field(idx, F_BURST)) ||
                m_arcache !== 4'(field(idx, F_CACHE))) begin
                $display("[FAIL] %0t: burst %0d master burst %0d cache %h, expected %0d %h",
                         $time, idx, m_arburst, m_arcache, field(idx, F_BURST),
                         field(idx, F_CACHE));
                ar_errors++;
            end
        end
    endtask

    task automatic check_slave_beat;
        logic [31:0] addr;
        logic [31:0] exp_data;
        logic        exp_last;
        if (rsp_idx >= req_sent) begin
            $display("[FAIL] %0t: slave beat %h with no request outstanding", $time, s_rdata);
            r_errors++;
        end else begin
            addr = beat_addr(field(rsp_idx, F_ADDR), 3'(field(rsp_idx, F_SIZE)), beat_n);
            exp_data = lane_bytes(addr);
            exp_last = (beat_n == field(rsp_idx, F_LEN));
            if (s_rdata !== exp_data) begin
                $display("[FAIL] %0t: burst %0d beat %0d data %h, expected %h",
                         $time, rsp_idx, beat_n, s_rdata, exp_data);
                r_errors++;
            end
            if (s_rid !== 4'(field(rsp_idx, F_ID)) || s_rresp !== 2'(field(rsp_idx, F_RESP))) begin
                $display("[FAIL] %0t: burst %0d beat %0d id %h resp %0d, expected %h %0d",
                         $time, rsp_idx, beat_n, s_rid, s_rresp,
                         field(rsp_idx, F_ID), field(rsp_idx, F_RESP));
                r_errors++;
            end
            if (s_rlast !== exp_last) begin
                $display("[FAIL] %0t: burst %0d beat %0d last %b, expected %b",
                         $time, rsp_idx, beat_n, s_rlast, exp_last);
                r_errors++;
            end
            if (exp_last) begin
                rsp_idx++;
                beat_n = 0;
            end else begin
                beat_n++;
            end
        end
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: bursts did not complete within %0d cycles", CYCLE_LIMIT);
            $display(">>> FAIL");
            $finish;
        end
    end

    // master memory, one burst at a time with random rvalid gaps
    initial begin : memory_model
        logic [31:0] addr;
        logic [7:0]  len;
        logic [2:0]  size;
        logic [1:0]  resp;
        int          idx;
        idx = 0;
        forever begin
            @(negedge clk);
            if (!rst && m_arvalid) begin
                addr = m_araddr;
                len = m_arlen;
                size = m_arsize;
                resp = (idx < NUM_BURSTS) ? 2'(field(idx, F_RESP)) : 2'b00;
                check_master_ar(idx);
                m_arready = 1'b1;
                @(negedge clk);
                m_arready = 1'b0;
                for (int n = 0; n <= len; n++) begin
                    while (($random(seed) & 3) == 0) @(negedge clk);
                    m_rvalid = 1'b1;
                    m_rdata = wide_word(beat_addr(addr, size, n));
                    m_rresp = resp;
                    m_rlast = (n == len);
                    while (!m_rready) @(negedge clk);
                    @(negedge clk);
                    m_rvalid = 1'b0;
                    m_rlast = 1'b0;
                end
                idx++;
            end
        end
    end

    // odd bursts see heavy rready stalls
    initial begin : slave_monitor
        forever begin
            @(negedge clk);
            if (!rst) begin
                if (rsp_idx % 2 == 1) begin
                    s_rready = ($random(seed) & 3) == 0;
                end else begin
                    s_rready = ($random(seed) & 3) != 0;
                end
                if (s_rvalid && s_rready) begin
                    check_slave_beat;
                end
            end
        end
    end

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        s_arid = '0;
        s_araddr = '0;
        s_arlen = '0;
        s_arsize = '0;
        s_arburst = '0;
        s_arcache = '0;
        s_arvalid = 1'b0;
        s_rready = 1'b0;
        m_arready = 1'b0;
        m_rdata = '0;
        m_rresp = '0;
        m_rlast = 1'b0;
        m_rvalid = 1'b0;
        seed = 32'h97ba27c7;
        ar_errors = 0;
        r_errors = 0;
        req_sent = 0;
        rsp_idx = 0;
        beat_n = 0;
        $readmemh("tb/rd_upsizer_golden.txt", golden);

        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        check_arready_after_reset;

        for (int b = 0; b < NUM_BURSTS; b++) begin
            send_request(b);
            while (rsp_idx <= b) @(negedge clk);
        end
        repeat (4) @(negedge clk);

        $display("error counts: ar %0d, r %0d", ar_errors, r_errors);
        if (ar_errors == 0 && r_errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule
